// File: common/actor_pkg.sv
`default_nettype none

package actor_pkg;

    // Field widths of the command word and the datapath.
    localparam int WORD_W      = 16;
    localparam int INSTR_W     = 8;
    localparam int SHIFT_W     = 3;
    localparam int COUNT_W     = 5;
    localparam int ERR_W       = 2;

    localparam int COEFF_DEPTH = 32;
    localparam int ADDR_W      = $clog2(COEFF_DEPTH);

    // Command word is instr[15:8], arg1[7:5], arg2[4:0].
    localparam int INSTR_LSB   = WORD_W - INSTR_W;
    localparam int ARG1_LSB    = COUNT_W;

    // Zero bits between the opcode byte and the error code in a status word.
    localparam int STATUS_PAD_W = WORD_W - INSTR_W - ERR_W;

    typedef logic signed [WORD_W-1:0]   word_t;   // Coefficients, x values and results.
    typedef logic signed [2*WORD_W-1:0] prod_t;   // Full Horner product before the shift.
    typedef logic [INSTR_W-1:0]         instr_t;
    typedef logic [SHIFT_W-1:0]         shift_t;  // Fixed-point right shift per step.
    typedef logic [COUNT_W-1:0]         count_t;
    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [ERR_W-1:0]           error_t;

    // Opcodes. The gaps in the numbering are unused and decode as illegal.
    localparam instr_t OP_STP = 8'd1;  // Store arg2 coefficients.
    localparam instr_t OP_EVP = 8'd2;  // Evaluate one x.
    localparam instr_t OP_EVB = 8'd3;  // Evaluate a block of arg2 x values.
    localparam instr_t OP_RST = 8'd5;  // Clear the coefficient count.

    // Error codes carried in the low bits of every status word.
    localparam error_t ERR_NONE   = 2'd0;
    localparam error_t ERR_OPCODE = 2'd1;
    localparam error_t ERR_EMPTY  = 2'd2;  // Evaluation with no stored coefficients.

endpackage

`default_nettype wire

// File: common/cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded command passed from the command decoder to the firing FSM.
interface cmd_if
    import actor_pkg::*;
(
    input logic clk,
    input logic rst
);

    logic   start;  // One-cycle request for the next command.
    logic   done;   // One-cycle pulse once the fields below are loaded.
    instr_t instr;
    shift_t arg1;
    count_t arg2;
    error_t error;

    modport decoder
    (
        input  clk, rst, start,
        output done, instr, arg1, arg2, error
    );

    modport firing
    (
        input  clk, rst, done, instr, arg1, arg2, error,
        output start
    );

endinterface

`default_nettype wire

// File: design/coeff_ram.sv
`timescale 1ns/1ps
`default_nettype none

module coeff_ram
    import actor_pkg::*;
(
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    // Address 0 holds the highest order coefficient.
    word_t mem [COEFF_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Read data trails the address by one cycle.
    end

endmodule

`default_nettype wire

// File: get_command/get_command_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module get_command_fsm
    import actor_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  word_t  command_in,
    input  logic   command_valid,
    output logic   rd_command,
    cmd_if.decoder cmd
);

    typedef enum logic [1:0]
    {
        G_IDLE,
        G_WAIT,
        G_DECODE
    } get_cmd_state_t;

    get_cmd_state_t state_q;
    instr_t         opcode;

    assign opcode = command_in[INSTR_LSB +: INSTR_W];

    // The word is taken from the FIFO in the same cycle that it shows as valid.
    assign rd_command = (state_q == G_WAIT) && command_valid;
    assign cmd.done   = (state_q == G_DECODE);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q <= G_IDLE;
        end
        else
        begin
            case (state_q)
                G_IDLE:
                begin
                    if (cmd.start)
                    begin
                        state_q <= G_WAIT;
                    end
                end
                G_WAIT:
                begin
                    if (command_valid)
                    begin
                        state_q <= G_DECODE;
                    end
                end
                G_DECODE:
                begin
                    state_q <= G_IDLE;
                end
                default:
                begin
                    state_q <= G_IDLE;
                end
            endcase
        end
    end

    // Fields stay put from done until the next command is read.
    always_ff @(posedge clk)
    begin
        if (rd_command)
        begin
            cmd.instr <= opcode;
            cmd.arg1  <= command_in[ARG1_LSB +: SHIFT_W];
            cmd.arg2  <= command_in[COUNT_W-1:0];
            case (opcode)
                OP_STP, OP_EVP, OP_EVB, OP_RST: cmd.error <= ERR_NONE;
                default:                        cmd.error <= ERR_OPCODE;
            endcase
        end
    end

    // A command is only read while one is offered.
    a_rd_command: assert property (@(posedge clk) disable iff (!rst)
        rd_command |-> command_valid)
        else $error("rd_command without command_valid");

    // The firing FSM asks for a new command only when the decoder is free.
    a_start_idle: assert property (@(posedge clk) disable iff (!rst)
        cmd.start |-> (state_q == G_IDLE))
        else $error("start while the decoder is busy");

endmodule

`default_nettype wire

// File: firing_state/firing_state_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module firing_state_fsm
    import actor_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t data_in,
    input  logic  data_valid,
    output logic  rd_data,
    output word_t result_out,
    output logic  wr_result,
    input  logic  result_full,
    output word_t status_out,
    output logic  wr_status,
    input  logic  status_full,
    cmd_if.firing cmd,
    output logic  ram_wr_en,
    output addr_t ram_addr,
    output word_t ram_wdata,
    input  word_t ram_rdata
);

    typedef enum logic [3:0]
    {
        S_IDLE,      // Only after reset, so start stays low while rst is held.
        S_START,
        S_WAIT_CMD,
        S_STORE,
        S_READ_X,
        S_FETCH,
        S_STEP,
        S_RESULT,
        S_STATUS
    } firing_state_t;

    firing_state_t state_q;
    count_t        count_q;   // Number of valid coefficients in the RAM.
    count_t        remain_q;  // x values still to evaluate in this command.
    addr_t         addr_q;
    error_t        err_q;
    word_t         x_q;
    word_t         acc_q;
    prod_t         prod;
    prod_t         prod_shift;
    word_t         acc_next;
    logic          last_coeff;

    // One Horner step. The sum wraps at the word width.
    always_comb
    begin
        prod       = acc_q * x_q;
        prod_shift = prod >>> cmd.arg1;
        acc_next   = prod_shift[WORD_W-1:0] + ram_rdata;
    end

    assign last_coeff = (addr_q == addr_t'(count_q - 1'b1));

    assign cmd.start  = (state_q == S_START);
    assign rd_data    = ((state_q == S_STORE) || (state_q == S_READ_X)) && data_valid;
    assign ram_wr_en  = (state_q == S_STORE) && data_valid;
    assign ram_addr   = addr_q;
    assign ram_wdata  = data_in;
    assign result_out = acc_q;
    assign wr_result  = (state_q == S_RESULT) && !result_full;
    assign status_out = {cmd.instr, {STATUS_PAD_W{1'b0}}, err_q};
    assign wr_status  = (state_q == S_STATUS) && !status_full;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q  <= S_IDLE;
            count_q  <= '0;
            remain_q <= '0;
            addr_q   <= '0;
            err_q    <= ERR_NONE;
        end
        else
        begin
            case (state_q)
                S_IDLE:
                begin
                    state_q <= S_START;
                end
                S_START:
                begin
                    state_q <= S_WAIT_CMD;
                end
                S_WAIT_CMD:
                begin
                    if (cmd.done)
                    begin
                        err_q   <= cmd.error;
                        addr_q  <= '0;
                        state_q <= S_STATUS;  // Illegal opcodes only report.
                        if (cmd.error == ERR_NONE)
                        begin
                            case (cmd.instr)
                                OP_STP:
                                begin
                                    if (cmd.arg2 == '0)
                                        count_q <= '0;
                                    else
                                        state_q <= S_STORE;
                                end
                                OP_EVP, OP_EVB:
                                begin
                                    // A single evaluation is a block of one.
                                    remain_q <= (cmd.instr == OP_EVP) ? count_t'(1) : cmd.arg2;
                                    if (count_q == '0)
                                        err_q <= ERR_EMPTY;
                                    else if ((cmd.instr == OP_EVP) || (cmd.arg2 != '0))
                                        state_q <= S_READ_X;
                                end
                                OP_RST:
                                begin
                                    count_q <= '0;
                                end
                                default:
                                begin
                                end
                            endcase
                        end
                    end
                end
                S_STORE:
                begin
                    if (data_valid)
                    begin
                        addr_q <= addr_q + 1'b1;
                        if (addr_q == addr_t'(cmd.arg2 - 1'b1))
                        begin
                            count_q <= cmd.arg2;  // New set is live once fully written.
                            state_q <= S_STATUS;
                        end
                    end
                end
                S_READ_X:
                begin
                    if (data_valid)
                    begin
                        addr_q  <= '0;
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH:
                begin
                    state_q <= S_STEP;  // RAM output settles for addr_q.
                end
                S_STEP:
                begin
                    addr_q  <= addr_q + 1'b1;
                    state_q <= last_coeff ? S_RESULT : S_FETCH;
                end
                S_RESULT:
                begin
                    if (!result_full)
                    begin
                        remain_q <= remain_q - 1'b1;
                        state_q  <= (remain_q == count_t'(1)) ? S_STATUS : S_READ_X;
                    end
                end
                S_STATUS:
                begin
                    if (!status_full)
                    begin
                        state_q <= S_START;
                    end
                end
                default:
                begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // The accumulator starts at zero, so the first step just loads the top coefficient.
    always_ff @(posedge clk)
    begin
        if ((state_q == S_READ_X) && data_valid)
        begin
            x_q   <= data_in;
            acc_q <= '0;
        end
        else if (state_q == S_STEP)
        begin
            acc_q <= acc_next;
        end
    end

    // No result goes into a full result FIFO.
    a_wr_result: assert property (@(posedge clk) disable iff (!rst)
        wr_result |-> !result_full)
        else $error("result written while the result FIFO is full");

    // No status word goes into a full status FIFO.
    a_wr_status: assert property (@(posedge clk) disable iff (!rst)
        wr_status |-> !status_full)
        else $error("status written while the status FIFO is full");

endmodule

`default_nettype wire

// File: design/poly_actor.sv
`timescale 1ns/1ps
`default_nettype none

module poly_actor
    import actor_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t command_in,
    input  logic  command_valid,
    output logic  rd_command,
    input  word_t data_in,
    input  logic  data_valid,
    output logic  rd_data,
    output word_t result_out,
    output logic  wr_result,
    input  logic  result_full,
    output word_t status_out,
    output logic  wr_status,
    input  logic  status_full
);

    logic  ram_wr_en;
    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;

    cmd_if u_cmd
    (
        .clk (clk),
        .rst (rst)
    );

    get_command_fsm u_get_command
    (
        .clk           (clk),
        .rst           (rst),
        .command_in    (command_in),
        .command_valid (command_valid),
        .rd_command    (rd_command),
        .cmd           (u_cmd.decoder)
    );

    coeff_ram u_coeff_ram
    (
        .clk   (clk),
        .wr_en (ram_wr_en),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    firing_state_fsm u_firing
    (
        .clk         (clk),
        .rst         (rst),
        .data_in     (data_in),
        .data_valid  (data_valid),
        .rd_data     (rd_data),
        .result_out  (result_out),
        .wr_result   (wr_result),
        .result_full (result_full),
        .status_out  (status_out),
        .wr_status   (wr_status),
        .status_full (status_full),
        .cmd         (u_cmd.firing),
        .ram_wr_en   (ram_wr_en),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

// File: tb/poly_model.svh
logic [31:0] rng_state;
word_t       model_coeff [COEFF_DEPTH];  // Index 0 is the highest order.
int          model_count;

// 32-bit xorshift, one new value per call.
function automatic logic [31:0] xorshift();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
endfunction

// Horner over the stored set. Each step is a 32-bit product, an arithmetic
// shift, a cut to 16 bits and a wrapping add of the next coefficient.
function automatic word_t horner(input word_t x, input shift_t shift);
    logic signed [31:0] p;
    word_t              acc;
    acc = '0;
    for (int i = 0; i < model_count; i++)
    begin
        p   = 32'(acc) * 32'(x);
        p   = p >>> shift;
        acc = p[15:0] + model_coeff[addr_t'(i)];
    end
    return acc;
endfunction

// Queues one command word with the data it needs, and the expected outputs.
task automatic run_command(input instr_t op, input shift_t shift, input count_t n);
    word_t  w;
    error_t err;
    int     num_x;
    err = ERR_NONE;
    cmd_q.push_back({op, shift, n});
    case (op)
        OP_STP:
        begin
            for (int i = 0; i < int'(n); i++)
            begin
                w = word_t'(xorshift());
                data_q.push_back(w);
                model_coeff[addr_t'(i)] = w;
            end
            model_count = int'(n);
        end
        OP_EVP, OP_EVB:
        begin
            num_x = (op == OP_EVP) ? 1 : int'(n);  // EVP ignores arg2.
            if (model_count == 0)
                err = ERR_EMPTY;
            else
            begin
                for (int k = 0; k < num_x; k++)
                begin
                    w = word_t'(xorshift());
                    data_q.push_back(w);
                    exp_res.push_back(horner(w, shift));
                end
            end
        end
        OP_RST:  model_count = 0;
        default: err = ERR_OPCODE;
    endcase
    exp_stat.push_back({op, 6'b0, err});
endtask

// File: tb/tb_poly_actor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_poly_actor
    import actor_pkg::*;
();

    localparam int PERIOD     = 40;
    localparam int N_BASIC    = 4;
    localparam int N_BLOCK    = 3;
    localparam int N_RANDOM   = 12;
    localparam int NUM_CMDS   = 5 + 2 * N_BASIC + 2 * N_BLOCK + 4 + N_RANDOM;
    localparam int CMD_CYCLES = 4000;  // Above 31 x values over 31 coefficients with stalls.
    localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * CMD_CYCLES * PERIOD;

    logic  clk;
    logic  rst;
    word_t command_in;
    logic  command_valid;
    logic  rd_command;
    word_t data_in;
    logic  data_valid;
    logic  rd_data;
    word_t result_out;
    logic  wr_result;
    logic  result_full;
    word_t status_out;
    logic  wr_status;
    logic  status_full;

    word_t cmd_q[$];      // Command FIFO contents.
    word_t data_q[$];
    word_t res_q[$];      // Words the DUT wrote.
    word_t stat_q[$];
    word_t exp_res[$];
    word_t exp_stat[$];
    bit    gaps;          // Random valid gaps and full flags when set.
    int    errors;
    int    test_errors;   // Error count when the current test began.
    int    tests;

    `include "poly_model.svh"

    poly_actor uut
    (
        .clk           (clk),
        .rst           (rst),
        .command_in    (command_in),
        .command_valid (command_valid),
        .rd_command    (rd_command),
        .data_in       (data_in),
        .data_valid    (data_valid),
        .rd_data       (rd_data),
        .result_out    (result_out),
        .wr_result     (wr_result),
        .result_full   (result_full),
        .status_out    (status_out),
        .wr_status     (wr_status),
        .status_full   (status_full)
    );

    task automatic log_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    // Waits for one status word per queued command, then checks all the DUT wrote.
    task automatic finish_test(input string name);
        int cycles;
        cycles = 0;
        while ((stat_q.size() < exp_stat.size()) && (cycles < exp_stat.size() * CMD_CYCLES))
        begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < exp_stat.size() * CMD_CYCLES)
            else log_error($sformatf("%s timed out waiting for status words", name));
        repeat (8) @(negedge clk);  // An extra write would land here.
        assert (res_q.size() == exp_res.size())
            else log_error($sformatf("FAILED %s result count: expected %0d, actual %0d",
                                     name, exp_res.size(), res_q.size()));
        assert (stat_q.size() == exp_stat.size())
            else log_error($sformatf("FAILED %s status count: expected %0d, actual %0d",
                                     name, exp_stat.size(), stat_q.size()));
        foreach (exp_res[i])
        begin
            if (i < res_q.size())
            begin
                assert (res_q[i] == exp_res[i])
                    else log_error($sformatf("FAILED %s result %0d: expected %h, actual %h",
                                             name, i, exp_res[i], res_q[i]));
            end
        end
        foreach (exp_stat[i])
        begin
            if (i < stat_q.size())
            begin
                assert (stat_q[i] == exp_stat[i])
                    else log_error($sformatf("FAILED %s status %0d: expected %h, actual %h",
                                             name, i, exp_stat[i], stat_q[i]));
            end
        end
        assert (data_q.size() == 0)
            else log_error($sformatf("FAILED %s unread data words: expected 0, actual %0d",
                                     name, data_q.size()));
        $display("test %s: %0d results, %0d status words, %0d errors",
                 name, res_q.size(), stat_q.size(), errors - test_errors);
        tests++;
        cmd_q.delete();
        data_q.delete();
        res_q.delete();
        stat_q.delete();
        exp_res.delete();
        exp_stat.delete();
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // FIFO models. Strobes are sampled mid-cycle and act at the next rising edge.
    initial
    begin : fifo_models
        logic        take_cmd;
        logic        take_data;
        logic        put_res;
        logic        put_stat;
        word_t       res_word;
        word_t       stat_word;
        logic [31:0] r;
        command_in    = '0;
        command_valid = 1'b0;
        data_in       = '0;
        data_valid    = 1'b0;
        result_full   = 1'b0;
        status_full   = 1'b0;
        forever
        begin
            @(negedge clk);
            take_cmd  = rd_command;
            take_data = rd_data;
            put_res   = wr_result;
            put_stat  = wr_status;
            res_word  = result_out;
            stat_word = status_out;
            assert (!rd_command || command_valid)
                else log_error("rd_command strobe while the command FIFO is empty");
            assert (!rd_data || data_valid)
                else log_error("rd_data strobe while the data FIFO is empty");
            assert (!wr_result || !result_full)
                else log_error("wr_result strobe while the result FIFO is full");
            assert (!wr_status || !status_full)
                else log_error("wr_status strobe while the status FIFO is full");
            @(posedge clk);
            #2;
            if (take_cmd && (cmd_q.size() > 0))
                void'(cmd_q.pop_front());
            if (take_data && (data_q.size() > 0))
                void'(data_q.pop_front());
            if (put_res)
                res_q.push_back(res_word);
            if (put_stat)
                stat_q.push_back(stat_word);
            r = gaps ? xorshift() : 32'hFFFF_FFFF;  // All ones means no gap and never full.
            command_valid = (cmd_q.size() > 0) && (r[1:0] != 2'd0);
            command_in    = (cmd_q.size() > 0) ? cmd_q[0] : '0;
            data_valid    = (data_q.size() > 0) && (r[3:2] != 2'd0);
            data_in       = (data_q.size() > 0) ? data_q[0] : '0;
            result_full   = (r[5:4] == 2'd0);
            status_full   = (r[7:6] == 2'd0);
        end
    end

    initial
    begin : main
        logic [31:0] r;
        instr_t      op;
        rst         = 1'b0;
        errors      = 0;
        tests       = 0;
        gaps        = 1'b0;
        rng_state   = 32'd76;
        model_count = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);

        // No coefficients yet, then a stored set cleared by RST.
        test_errors = errors;
        run_command(OP_EVP, 3'd0, 5'd0);
        run_command(OP_EVB, 3'd1, 5'd4);
        run_command(OP_STP, 3'd0, 5'd3);
        run_command(OP_RST, 3'd0, 5'd0);
        run_command(OP_EVP, 3'd2, 5'd0);
        finish_test("empty_count");

        test_errors = errors;
        repeat (N_BASIC)
        begin
            r = xorshift();
            run_command(OP_STP, 3'd0, count_t'(1 + r[7:0] % 31));
            run_command(OP_EVP, shift_t'(r[10:8]), count_t'(r[15:11]));
        end
        finish_test("store_then_eval");

        test_errors = errors;
        repeat (N_BLOCK)
        begin
            r = xorshift();
            run_command(OP_STP, 3'd0, count_t'(1 + r[7:0] % 31));
            run_command(OP_EVB, shift_t'(r[10:8]), count_t'(r[20:16]));
        end
        finish_test("block_eval");

        // Both bad opcodes carry an arg2 that would pull data if decoded.
        test_errors = errors;
        run_command(OP_STP, 3'd0, 5'd4);
        run_command(8'h04, 3'd2, 5'd7);
        run_command(8'hA5, 3'd0, 5'd3);
        run_command(OP_EVP, 3'd1, 5'd0);
        finish_test("illegal_opcode");

        test_errors = errors;
        gaps = 1'b1;
        repeat (N_RANDOM)
        begin
            r = xorshift();
            case (r[2:0])
                3'd0, 3'd1: op = OP_STP;
                3'd2:       op = OP_EVP;
                3'd3, 3'd4: op = OP_EVB;
                3'd5:       op = OP_RST;
                default:    op = 8'h80 | r[15:8];  // Top bit set is never a legal opcode.
            endcase
            run_command(op, shift_t'(r[18:16]), count_t'(r[28:24]));
        end
        finish_test("random_backpressure");
        gaps = 1'b0;

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+tb
common/actor_pkg.sv
common/cmd_if.sv
design/coeff_ram.sv
get_command/get_command_fsm.sv
firing_state/firing_state_fsm.sv
design/poly_actor.sv
tb/tb_poly_actor.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_poly_actor
RTL_TOP    = poly_actor
FILELIST   = all.f
LOG        = sim.log
PASS_MSG   = Done: no errors
FAIL_MSG   = Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir $(LOG)
